// ==== build.f ====
rtl/lsu_pkg.sv
rtl/lsu_intf.sv
rtl/ex_stage.sv
rtl/tlb.sv
rtl/mem_stage.sv
rtl/data_sram.sv
rtl/lsu_top.sv
testbench/lsu_properties.sv
testbench/tb_lsu.sv

// ==== rtl/data_sram.sv ====
`timescale 1ns/1ns

module data_sram import lsu_pkg::*; (
    input  logic clk,
    input  logic resetn,
    dmem_if.slave dm
);

    word_t mem [DMEM_WORDS];
    logic [1:0]         stall_cnt;
    logic [DMEM_AW-1:0] idx;
    logic               accept;
    logic [3:0]         rd_lanes;
    word_t              rd_mask;
    word_t              rdata_q;
    logic               data_ok_q;

    // free-running, addr_ok drops on every fourth cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            stall_cnt <= 2'd0;
        end else begin
            stall_cnt <= stall_cnt + 2'd1;
        end
    end

    assign dm.addr_ok = (stall_cnt != 2'd3);
    assign accept     = dm.req && dm.addr_ok;
    assign idx        = dm.addr[DMEM_AW+1:2];        // upper address bits ignored

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= (word_t'(i) * DMEM_INIT_STEP) ^ DMEM_INIT_XOR;
            end
        end else if (accept && dm.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (dm.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= dm.wdata[8*b +: 8];
                end
            end
        end
    end

    // lanes outside the access read back as zero
    always_comb begin
        case (dm.size)
            SIZE_B:  rd_lanes = 4'b0001 << dm.addr[1:0];
            SIZE_H:  rd_lanes = dm.addr[1] ? 4'b1100 : 4'b0011;
            default: rd_lanes = 4'b1111;
        endcase
        rd_mask = {{8{rd_lanes[3]}}, {8{rd_lanes[2]}}, {8{rd_lanes[1]}}, {8{rd_lanes[0]}}};
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= mem[idx] & rd_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= accept;                     // one-cycle response
        end
    end

    assign dm.data_ok = data_ok_q;
    assign dm.rdata   = rdata_q;

endmodule

// ==== rtl/ex_stage.sv ====
`timescale 1ns/1ns

module ex_stage import lsu_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     flush,
    input  logic     in_valid,
    output logic     in_allowin,
    input  mem_op_t  in_op,
    input  word_t    in_base,
    input  word_t    in_offset,
    input  word_t    in_wdata,
    input  reg_idx_t in_rd,
    input  logic     crmd_pg,
    input  plv_t     crmd_plv,
    input  asid_t    asid,
    input  logic [3:0] dmw0_plv_mask,
    input  logic [2:0] dmw0_vseg,
    input  logic [2:0] dmw0_pseg,
    input  logic [3:0] dmw1_plv_mask,
    input  logic [2:0] dmw1_vseg,
    input  logic [2:0] dmw1_pseg,
    ex_mem_if.ex       em,
    dmem_if.master     dm,
    tlb_search_if.ex   ts
);

    logic     ex_valid;
    mem_op_t  ex_op;
    word_t    ex_base;
    word_t    ex_offset;
    word_t    ex_wdata;
    reg_idx_t ex_rd;

    vaddr_t   vaddr;
    paddr_t   paddr;
    size_t    size;
    logic     is_store;
    logic     hit_dmw0;
    logic     hit_dmw1;
    logic     use_tlb;
    logic     excep;
    ecode_t   ecode;
    logic     need_req;
    logic     ex_ready;
    logic [3:0] strb;

    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            ex_valid <= 1'b0;
        end else if (in_allowin) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            ex_op     <= in_op;
            ex_base   <= in_base;
            ex_offset <= in_offset;
            ex_wdata  <= in_wdata;
            ex_rd     <= in_rd;
        end
    end

    assign vaddr    = ex_base + ex_offset;
    assign is_store = (ex_op == OP_ST_B) || (ex_op == OP_ST_H) || (ex_op == OP_ST_W);

    always_comb begin
        case (ex_op)
            OP_LD_B, OP_LD_BU, OP_ST_B: size = SIZE_B;
            OP_LD_H, OP_LD_HU, OP_ST_H: size = SIZE_H;
            default:                    size = SIZE_W;
        endcase
    end

    // direct-map windows, checked against the current privilege level
    assign hit_dmw0 = dmw0_plv_mask[crmd_plv] && (dmw0_vseg == vaddr[31:29]);
    assign hit_dmw1 = dmw1_plv_mask[crmd_plv] && (dmw1_vseg == vaddr[31:29]);
    assign use_tlb  = crmd_pg && !hit_dmw0 && !hit_dmw1;

    assign ts.vppn = vaddr[31:13];
    assign ts.asid = asid;

    always_comb begin
        if (!crmd_pg) begin
            paddr = vaddr;                               // direct translation
        end else if (hit_dmw0) begin
            paddr = {dmw0_pseg, vaddr[28:0]};
        end else if (hit_dmw1) begin
            paddr = {dmw1_pseg, vaddr[28:0]};
        end else if (ts.ps == PS_4M) begin
            paddr = {ts.ppn[19:9], vaddr[20:0]};
        end else begin
            paddr = {ts.ppn, vaddr[11:0]};
        end
    end

    // first match wins, ale highest
    always_comb begin
        excep = 1'b1;
        ecode = '0;
        if ((size == SIZE_H && vaddr[0]) || (size == SIZE_W && vaddr[1:0] != 2'b00)) begin
            ecode = ECODE_ALE;
        end else if (use_tlb && !ts.found) begin
            ecode = ECODE_TLBR;
        end else if (use_tlb && !ts.v) begin
            ecode = is_store ? ECODE_PIS : ECODE_PIL;
        end else if (use_tlb && (ts.plv < crmd_plv)) begin
            ecode = ECODE_PPI;
        end else if (use_tlb && is_store && !ts.d) begin
            ecode = ECODE_PME;
        end else begin
            excep = 1'b0;
        end
    end

    always_comb begin
        case (size)
            SIZE_B:  strb = 4'b0001 << paddr[1:0];
            SIZE_H:  strb = paddr[1] ? 4'b1100 : 4'b0011;
            default: strb = 4'b1111;
        endcase
    end

    // handshake toward memory and mem stage
    assign need_req   = ex_valid && !excep;
    assign dm.req     = need_req && !flush && em.allowin;
    assign ex_ready   = !need_req || (dm.req && dm.addr_ok);
    assign in_allowin = !ex_valid || (ex_ready && em.allowin);

    assign dm.wr    = is_store;
    assign dm.size  = size;
    assign dm.addr  = paddr;
    assign dm.wstrb = is_store ? strb : 4'b0000;

    always_comb begin
        case (size)
            SIZE_B:  dm.wdata = {4{ex_wdata[7:0]}};      // replicate across lanes
            SIZE_H:  dm.wdata = {2{ex_wdata[15:0]}};
            default: dm.wdata = ex_wdata;
        endcase
    end

    assign em.valid    = ex_valid && ex_ready && !flush;
    assign em.rd       = ex_rd;
    assign em.rf_we    = !is_store && !excep;
    assign em.load_op  = ex_op;
    assign em.byte_off = vaddr[1:0];
    assign em.excep    = excep;
    assign em.ecode    = ecode;
    assign em.badv     = vaddr;
    assign em.req_sent = !excep;

endmodule

// ==== rtl/lsu_intf.sv ====
`timescale 1ns/1ns

interface ex_mem_if import lsu_pkg::*; ();
    logic     valid;
    logic     allowin;
    reg_idx_t rd;
    logic     rf_we;
    mem_op_t  load_op;
    logic [1:0] byte_off;
    logic     excep;
    ecode_t   ecode;
    vaddr_t   badv;
    logic     req_sent;      // op has a data request in flight

    modport ex (
        output valid, rd, rf_we, load_op, byte_off, excep, ecode, badv, req_sent,
        input  allowin
    );

    modport mem (
        input  valid, rd, rf_we, load_op, byte_off, excep, ecode, badv, req_sent,
        output allowin
    );
endinterface

interface dmem_if import lsu_pkg::*; ();
    logic   req;
    logic   wr;
    size_t  size;
    logic [3:0] wstrb;
    paddr_t addr;
    word_t  wdata;
    logic   addr_ok;
    logic   data_ok;
    word_t  rdata;

    modport master (
        output req, wr, size, wstrb, addr, wdata,
        input  addr_ok
    );

    modport resp (
        input data_ok, rdata
    );

    modport slave (
        input  req, wr, size, wstrb, addr, wdata,
        output addr_ok, data_ok, rdata
    );
endinterface

interface tlb_search_if import lsu_pkg::*; ();
    vppn_t vppn;
    asid_t asid;
    logic  found;
    ppn_t  ppn;
    ps_t   ps;
    plv_t  plv;
    logic  d;
    logic  v;

    modport ex (
        output vppn, asid,
        input  found, ppn, ps, plv, d, v
    );

    modport tlb (
        input  vppn, asid,
        output found, ppn, ps, plv, d, v
    );
endinterface

// ==== rtl/lsu_pkg.sv ====
package lsu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  mem_op_t;
    typedef logic [18:0] vppn_t;     // vaddr[31:13]
    typedef logic [19:0] ppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [5:0]  ps_t;       // page size as log2 of bytes
    typedef logic [1:0]  size_t;     // access size on the data bus

    // micro-op codes, loads first
    localparam mem_op_t OP_LD_B  = 3'd0;
    localparam mem_op_t OP_LD_BU = 3'd1;
    localparam mem_op_t OP_LD_H  = 3'd2;
    localparam mem_op_t OP_LD_HU = 3'd3;
    localparam mem_op_t OP_LD_W  = 3'd4;
    localparam mem_op_t OP_ST_B  = 3'd5;
    localparam mem_op_t OP_ST_H  = 3'd6;
    localparam mem_op_t OP_ST_W  = 3'd7;

    localparam ecode_t ECODE_ALE  = 6'h09;   // misaligned address
    localparam ecode_t ECODE_TLBR = 6'h3f;   // tlb refill
    localparam ecode_t ECODE_PIL  = 6'h01;   // page invalid on load
    localparam ecode_t ECODE_PIS  = 6'h02;   // page invalid on store
    localparam ecode_t ECODE_PPI  = 6'h07;   // privilege violation
    localparam ecode_t ECODE_PME  = 6'h04;   // page modify

    localparam ps_t PS_4K = 6'd12;
    localparam ps_t PS_4M = 6'd21;

    localparam size_t SIZE_B = 2'd0;
    localparam size_t SIZE_H = 2'd1;
    localparam size_t SIZE_W = 2'd2;

    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W   = 4;

    localparam int DMEM_AW    = 8;             // word address bits
    localparam int DMEM_WORDS = 1 << DMEM_AW;

    // reset contents of the data ram, word i = i * step ^ xor
    localparam word_t DMEM_INIT_STEP = 32'h0101_0101;
    localparam word_t DMEM_INIT_XOR  = 32'ha5a5_a5a5;

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_WAIT,
        MS_DRAIN
    } mem_state_t;

endpackage

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top import lsu_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     in_valid,
    output logic     in_allowin,
    input  mem_op_t  in_op,
    input  word_t    in_base,
    input  word_t    in_offset,
    input  word_t    in_wdata,
    input  reg_idx_t in_rd,
    input  logic     crmd_pg,
    input  plv_t     crmd_plv,
    input  asid_t    asid,
    input  logic [3:0] dmw0_plv_mask,
    input  logic [2:0] dmw0_vseg,
    input  logic [2:0] dmw0_pseg,
    input  logic [3:0] dmw1_plv_mask,
    input  logic [2:0] dmw1_vseg,
    input  logic [2:0] dmw1_pseg,
    input  logic     tlbwr_en,
    input  logic [TLB_IDX_W-1:0] tlbwr_index,
    input  vppn_t    tlbwr_vppn,
    input  asid_t    tlbwr_asid,
    input  ps_t      tlbwr_ps,
    input  ppn_t     tlbwr_ppn,
    input  plv_t     tlbwr_plv,
    input  logic     tlbwr_v,
    input  logic     tlbwr_d,
    input  logic     flush,
    output logic     out_valid,
    output reg_idx_t out_rd,
    output logic     out_rf_we,
    output word_t    out_result,
    output logic     out_excep,
    output ecode_t   out_ecode,
    output vaddr_t   out_badv
);

    ex_mem_if     em_if ();
    dmem_if       dm_if ();
    tlb_search_if ts_if ();

    // address, translation and request issue
    ex_stage u_ex_stage (
        .*,
        .em (em_if.ex),
        .dm (dm_if.master),
        .ts (ts_if.ex)
    );

    tlb u_tlb (
        .*,
        .ts (ts_if.tlb)
    );

    // response wait and load extension
    mem_stage u_mem_stage (
        .*,
        .em (em_if.mem),
        .dm (dm_if.resp)
    );

    data_sram u_data_sram (
        .*,
        .dm (dm_if.slave)
    );

endmodule

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage import lsu_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     flush,
    ex_mem_if.mem    em,
    dmem_if.resp     dm,
    output logic     out_valid,
    output reg_idx_t out_rd,
    output logic     out_rf_we,
    output word_t    out_result,
    output logic     out_excep,
    output ecode_t   out_ecode,
    output vaddr_t   out_badv
);

    mem_state_t state;
    mem_state_t state_nxt;
    logic       accept;
    logic       m_pend;          // op without request, leaves next cycle
    mem_op_t    m_op;
    logic [1:0] m_off;
    word_t      lane;
    word_t      ext;

    assign em.allowin = (state == MS_IDLE) || (state == MS_WAIT && dm.data_ok);
    assign accept     = em.valid && em.allowin;

    always_comb begin
        state_nxt = state;
        case (state)
            MS_IDLE: begin
                if (accept && em.req_sent) begin
                    state_nxt = MS_WAIT;
                end
            end
            MS_WAIT: begin
                if (dm.data_ok) begin
                    state_nxt = (accept && em.req_sent) ? MS_WAIT : MS_IDLE;
                end else if (flush) begin
                    state_nxt = MS_DRAIN;                // response still owed
                end
            end
            MS_DRAIN: begin
                if (dm.data_ok) begin
                    state_nxt = MS_IDLE;
                end
            end
            default: state_nxt = MS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state  <= MS_IDLE;
            m_pend <= 1'b0;
        end else begin
            state  <= state_nxt;
            m_pend <= accept && !em.req_sent;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_rd    <= em.rd;
            out_rf_we <= em.rf_we;
            m_op      <= em.load_op;
            m_off     <= em.byte_off;
            out_excep <= em.excep;
            out_ecode <= em.ecode;
            out_badv  <= em.badv;
        end
    end

    assign lane = dm.rdata >> {m_off, 3'b000};   // move addressed bytes to bit 0

    always_comb begin
        case (m_op)
            OP_LD_B:  ext = {{24{lane[7]}}, lane[7:0]};
            OP_LD_BU: ext = {24'b0, lane[7:0]};
            OP_LD_H:  ext = {{16{lane[15]}}, lane[15:0]};
            OP_LD_HU: ext = {16'b0, lane[15:0]};
            default:  ext = dm.rdata;
        endcase
    end

    assign out_result = out_rf_we ? ext : '0;
    assign out_valid  = !flush && (m_pend || (state == MS_WAIT && dm.data_ok));

endmodule

// ==== rtl/tlb.sv ====
`timescale 1ns/1ns

module tlb import lsu_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     tlbwr_en,
    input  logic [TLB_IDX_W-1:0] tlbwr_index,
    input  vppn_t    tlbwr_vppn,
    input  asid_t    tlbwr_asid,
    input  ps_t      tlbwr_ps,
    input  ppn_t     tlbwr_ppn,
    input  plv_t     tlbwr_plv,
    input  logic     tlbwr_v,
    input  logic     tlbwr_d,
    tlb_search_if.tlb ts
);

    logic [TLB_ENTRIES-1:0] e_valid;
    vppn_t e_vppn [TLB_ENTRIES];
    asid_t e_asid [TLB_ENTRIES];
    ps_t   e_ps   [TLB_ENTRIES];
    ppn_t  e_ppn  [TLB_ENTRIES];
    plv_t  e_plv  [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] e_v;
    logic [TLB_ENTRIES-1:0] e_d;

    logic [TLB_ENTRIES-1:0] match;
    logic [TLB_IDX_W-1:0]   hit_idx;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            e_valid <= '0;
        end else if (tlbwr_en) begin
            e_valid[tlbwr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlbwr_en) begin
            e_vppn[tlbwr_index] <= tlbwr_vppn;
            e_asid[tlbwr_index] <= tlbwr_asid;
            e_ps[tlbwr_index]   <= tlbwr_ps;
            e_ppn[tlbwr_index]  <= tlbwr_ppn;
            e_plv[tlbwr_index]  <= tlbwr_plv;
            e_v[tlbwr_index]    <= tlbwr_v;
            e_d[tlbwr_index]    <= tlbwr_d;
        end
    end

    // 4M pages compare only the upper vppn bits
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = e_valid[i] && (e_asid[i] == ts.asid) &&
                       ((e_ps[i] == PS_4M) ? (e_vppn[i][18:9] == ts.vppn[18:9])
                                           : (e_vppn[i] == ts.vppn));
        end
    end

    always_comb begin
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = TLB_IDX_W'(i);                 // lowest index wins
            end
        end
    end

    assign ts.found = |match;
    assign ts.ppn   = e_ppn[hit_idx];
    assign ts.ps    = e_ps[hit_idx];
    assign ts.plv   = e_plv[hit_idx];
    assign ts.d     = e_d[hit_idx];
    assign ts.v     = e_v[hit_idx];

endmodule

// ==== testbench/lsu_properties.sv ====
`timescale 1ns/1ns

module lsu_properties (
    input logic clk,
    input logic resetn,
    input logic in_allowin,
    input logic out_valid,
    input logic req,
    input logic addr_ok,
    input logic data_ok,
    input logic mem_accept
);

    // first cycle out of reset
    reset_quiet: assert property (@(posedge clk) $rose(resetn) |-> !out_valid && !req)
        else $error("out_valid or req high right after reset");

    reset_allowin: assert property (@(posedge clk) $rose(resetn) |-> in_allowin)
        else $error("in_allowin low right after reset");

    data_ok_after_req: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> $past(req && addr_ok))
        else $error("data_ok without an accepted request");

    // back-to-back results need a fresh op in mem
    one_result_per_op: assert property (@(posedge clk) disable iff (!resetn)
        (out_valid && $past(out_valid)) |-> $past(mem_accept))
        else $error("out_valid repeated for the same op");

endmodule

bind lsu_top lsu_properties i_props (
    .clk        (clk),
    .resetn     (resetn),
    .in_allowin (in_allowin),
    .out_valid  (out_valid),
    .req        (dm_if.req),
    .addr_ok    (dm_if.addr_ok),
    .data_ok    (dm_if.data_ok),
    .mem_accept (em_if.valid && em_if.allowin)
);

// ==== testbench/tb_lsu.sv ====
`timescale 1ns/1ns

module tb_lsu import lsu_pkg::*; ();

    typedef struct packed {
        reg_idx_t rd;
        logic     we;
        word_t    result;
        logic     excep;
        ecode_t   ecode;
        vaddr_t   badv;
    } exp_t;

    localparam int RESET_CYCLES = 16;
    localparam int TOTAL_OPS    = 60 + 48 + 50 + 50 + 80 + 15;
    localparam int CYCLE_LIMIT  = TOTAL_OPS * 10 + RESET_CYCLES + 200;

    logic clk, resetn, in_valid, in_allowin, crmd_pg, flush;
    mem_op_t in_op;
    word_t in_base, in_offset, in_wdata;
    reg_idx_t in_rd;
    plv_t crmd_plv;
    asid_t asid;
    logic [3:0] dmw0_plv_mask, dmw1_plv_mask;
    logic [2:0] dmw0_vseg, dmw0_pseg, dmw1_vseg, dmw1_pseg;
    logic tlbwr_en, tlbwr_v, tlbwr_d;
    logic [TLB_IDX_W-1:0] tlbwr_index;
    vppn_t tlbwr_vppn;
    asid_t tlbwr_asid;
    ps_t tlbwr_ps;
    ppn_t tlbwr_ppn;
    plv_t tlbwr_plv;
    logic out_valid, out_rf_we, out_excep;
    reg_idx_t out_rd;
    word_t out_result;
    ecode_t out_ecode;
    vaddr_t out_badv;

    word_t mem_model [DMEM_WORDS];
    logic  m_valid [TLB_ENTRIES];
    vppn_t m_vppn [TLB_ENTRIES];
    asid_t m_asid [TLB_ENTRIES];
    ps_t   m_ps [TLB_ENTRIES];
    ppn_t  m_ppn [TLB_ENTRIES];
    plv_t  m_plv [TLB_ENTRIES];
    logic  m_v [TLB_ENTRIES];
    logic  m_d [TLB_ENTRIES];
    exp_t  exp_q [$];
    logic [15:0] lfsr = 16'd57417;
    int errors = 0;
    int checks = 0;
    int cycle_cnt = 0;

    lsu_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles with %0d ops still pending",
                     CYCLE_LIMIT, exp_q.size());
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    // expected result of one op and the memory update of a store
    function automatic exp_t model_op(input mem_op_t op, input word_t base, input word_t offset,
                                      input word_t wdata, input reg_idx_t rd);
        exp_t e;
        vaddr_t va;
        paddr_t pa;
        size_t sz;
        logic st, tlb_used, found;
        int hit;
        word_t w;
        va = base + offset;
        st = (op >= OP_ST_B);
        sz = (op == OP_LD_B || op == OP_LD_BU || op == OP_ST_B) ? SIZE_B :
             (op == OP_LD_H || op == OP_LD_HU || op == OP_ST_H) ? SIZE_H : SIZE_W;
        tlb_used = 1'b0;
        found = 1'b0;
        hit = 0;
        pa = va;
        if (crmd_pg) begin
            if (dmw0_plv_mask[crmd_plv] && dmw0_vseg == va[31:29]) begin
                pa = {dmw0_pseg, va[28:0]};
            end else if (dmw1_plv_mask[crmd_plv] && dmw1_vseg == va[31:29]) begin
                pa = {dmw1_pseg, va[28:0]};
            end else begin
                tlb_used = 1'b1;
                for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
                    if (m_valid[i] && m_asid[i] == asid &&
                        (m_ps[i] == PS_4M ? m_vppn[i][18:9] == va[31:22]
                                          : m_vppn[i] == va[31:13])) begin
                        found = 1'b1;
                        hit = i;
                    end
                end
                pa = (m_ps[hit] == PS_4M) ? {m_ppn[hit][19:9], va[20:0]} : {m_ppn[hit], va[11:0]};
            end
        end
        e.rd = rd;
        e.badv = va;
        e.excep = 1'b1;
        e.ecode = '0;
        if ((sz == SIZE_H && va[0]) || (sz == SIZE_W && va[1:0] != 2'b00)) begin
            e.ecode = ECODE_ALE;
        end else if (tlb_used && !found) begin
            e.ecode = ECODE_TLBR;
        end else if (tlb_used && !m_v[hit]) begin
            e.ecode = st ? ECODE_PIS : ECODE_PIL;
        end else if (tlb_used && m_plv[hit] < crmd_plv) begin
            e.ecode = ECODE_PPI;
        end else if (tlb_used && st && !m_d[hit]) begin
            e.ecode = ECODE_PME;
        end else begin
            e.excep = 1'b0;
        end
        e.we = !st && !e.excep;
        e.result = '0;
        if (!e.excep) begin
            w = mem_model[pa[DMEM_AW+1:2]];
            if (st) begin
                case (sz)
                    SIZE_B:  w[8*pa[1:0] +: 8] = wdata[7:0];
                    SIZE_H:  w[16*pa[1] +: 16] = wdata[15:0];
                    default: w = wdata;
                endcase
                mem_model[pa[DMEM_AW+1:2]] = w;
            end else begin
                w = w >> (8 * va[1:0]);
                case (op)
                    OP_LD_B:  e.result = {{24{w[7]}}, w[7:0]};
                    OP_LD_BU: e.result = {24'b0, w[7:0]};
                    OP_LD_H:  e.result = {{16{w[15]}}, w[15:0]};
                    OP_LD_HU: e.result = {16'b0, w[15:0]};
                    default:  e.result = w;
                endcase
            end
        end
        return e;
    endfunction

    task automatic check_field(input string name, input word_t got, input word_t want);
        assert (got === want) else begin
            $display("Error: %s is %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    always @(negedge clk) begin
        exp_t e;
        if (resetn && out_valid) begin
            checks++;
            assert (exp_q.size() != 0) else begin
                $display("result delivered with no op outstanding");
                errors++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_field("out_rd", word_t'(out_rd), word_t'(e.rd));
                check_field("out_rf_we", word_t'(out_rf_we), word_t'(e.we));
                check_field("out_result", out_result, e.result);
                check_field("out_excep", word_t'(out_excep), word_t'(e.excep));
                check_field("out_ecode", word_t'(out_ecode), word_t'(e.ecode));
                check_field("out_badv", out_badv, e.badv);
            end
        end
    end

    // starts 2 ns after an edge and returns 2 ns after the accepting edge
    task automatic issue_op(input mem_op_t op, input word_t base, input word_t offset,
                            input word_t wdata, input reg_idx_t rd);
        logic acc;
        in_op = op;
        in_base = base;
        in_offset = offset;
        in_wdata = wdata;
        in_rd = rd;
        in_valid = 1'b1;
        acc = 1'b0;
        while (!acc) begin
            @(negedge clk);
            acc = in_allowin;
            if (acc) begin
                exp_q.push_back(model_op(op, base, offset, wdata, rd));
            end
            @(posedge clk);
            #2;
        end
        in_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic send_random(input word_t region, input int span, input bit aligned,
                               input bit loads_only, input int gap_bits);
        mem_op_t op;
        vaddr_t va;
        word_t off;
        op = mem_op_t'(rand_bits(3));
        if (loads_only) begin
            op = mem_op_t'(op % 5);
        end
        va = region | rand_bits(span);
        if (aligned && (op == OP_LD_H || op == OP_LD_HU || op == OP_ST_H)) begin
            va[0] = 1'b0;
        end else if (aligned && (op == OP_LD_W || op == OP_ST_W)) begin
            va[1:0] = 2'b00;
        end
        off = rand_bits(12);
        issue_op(op, va - off, off, rand_bits(32), reg_idx_t'(rand_bits(5)));
        if (gap_bits > 0) begin
            idle_cycles(rand_bits(gap_bits));
        end
    endtask

    task automatic write_tlb(input int idx, input vppn_t vppn, input asid_t as, input ps_t ps,
                             input ppn_t ppn, input plv_t plv, input logic v, input logic d);
        tlbwr_en = 1'b1;
        tlbwr_index = TLB_IDX_W'(idx);
        tlbwr_vppn = vppn;
        tlbwr_asid = as;
        tlbwr_ps = ps;
        tlbwr_ppn = ppn;
        tlbwr_plv = plv;
        tlbwr_v = v;
        tlbwr_d = d;
        @(posedge clk);
        #2;
        tlbwr_en = 1'b0;
        m_valid[idx] = 1'b1;
        m_vppn[idx] = vppn;
        m_asid[idx] = as;
        m_ps[idx] = ps;
        m_ppn[idx] = ppn;
        m_plv[idx] = plv;
        m_v[idx] = v;
        m_d[idx] = d;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic end_test(input int num, input string name, input int err_before);
        drain();
        $display("test %0d %s: %0d errors", num, name, errors - err_before);
    endtask

    initial begin
        int e0;
        word_t region;
        resetn = 1'b0;
        in_valid = 1'b0;
        in_op = OP_LD_W;
        in_base = '0;
        in_offset = '0;
        in_wdata = '0;
        in_rd = '0;
        crmd_pg = 1'b0;
        crmd_plv = 2'd0;
        asid = 10'h015;
        dmw0_plv_mask = 4'b0001;   // plv0 only
        dmw0_vseg = 3'b100;
        dmw0_pseg = 3'b000;
        dmw1_plv_mask = 4'b1000;   // plv3 only on the same segment
        dmw1_vseg = 3'b100;
        dmw1_pseg = 3'b001;
        tlbwr_en = 1'b0;
        tlbwr_index = '0;
        tlbwr_vppn = '0;
        tlbwr_asid = '0;
        tlbwr_ps = PS_4K;
        tlbwr_ppn = '0;
        tlbwr_plv = '0;
        tlbwr_v = 1'b0;
        tlbwr_d = 1'b0;
        flush = 1'b0;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            mem_model[i] = (word_t'(i) * 32'h0101_0101) ^ 32'ha5a5_a5a5;
        end
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        resetn = 1'b1;

        e0 = errors;
        repeat (60) send_random(32'h0000_0000, 32, 1'b1, 1'b0, 0);
        end_test(1, "direct access", e0);

        e0 = errors;
        crmd_pg = 1'b1;
        for (int p = 0; p < 3; p++) begin
            crmd_plv = (p == 0) ? 2'd0 : (p == 1) ? 2'd3 : 2'd1;   // dmw0 then dmw1 then tlb miss
            repeat (16) begin
                region = rand_bits(1) ? 32'h8000_0000 : 32'ha000_0000;
                send_random(region, 10, 1'b1, 1'b0, 1);
            end
            drain();
        end
        end_test(2, "direct-map windows", e0);

        e0 = errors;
        crmd_plv = 2'd3;
        write_tlb(0, 19'h00200, 10'h015, PS_4K, 20'h00012, 2'd3, 1'b1, 1'b1);
        write_tlb(1, 19'h00400, 10'h015, PS_4M, 20'h00a00, 2'd3, 1'b1, 1'b1);
        write_tlb(2, 19'h00300, 10'h015, PS_4K, 20'h00034, 2'd0, 1'b0, 1'b1);
        write_tlb(3, 19'h00380, 10'h015, PS_4K, 20'h00056, 2'd0, 1'b1, 1'b0);
        write_tlb(4, 19'h003a0, 10'h015, PS_4K, 20'h00078, 2'd3, 1'b1, 1'b0);
        write_tlb(5, 19'h00280, 10'h2aa, PS_4K, 20'h0009a, 2'd3, 1'b1, 1'b1);
        repeat (50) begin
            region = rand_bits(1) ? 32'h0040_0000 : 32'h0080_0000;
            send_random(region, (region == 32'h0040_0000) ? 13 : 22, 1'b1, 1'b0, 1);
        end
        end_test(3, "tlb translation", e0);

        e0 = errors;
        repeat (50) begin
            case (rand_bits(3) % 6)
                0: region = 32'h0040_0000;
                1: region = 32'h0060_0000;   // invalid page that also fails plv
                2: region = 32'h0070_0000;   // plv fault on a clean page
                3: region = 32'h0074_0000;
                4: region = 32'h0050_0000;   // refill for the other asid
                default: region = 32'h00f0_0000;
            endcase
            send_random(region, 12, 1'b0, 1'b0, 1);
        end
        end_test(4, "exceptions", e0);

        e0 = errors;
        crmd_pg = 1'b0;
        repeat (80) send_random(32'h0000_0000, 32, 1'b1, 1'b0, 2);
        end_test(5, "valid gaps and stalls", e0);

        e0 = errors;
        repeat (3) send_random(32'h0000_0000, 32, 1'b1, 1'b1, 0);
        flush = 1'b1;
        exp_q.delete();                  // in-flight loads are dropped
        @(posedge clk);
        #2;
        flush = 1'b0;
        repeat (12) send_random(32'h0000_0000, 32, 1'b1, 1'b1, 1);
        end_test(6, "flush", e0);

        $display("tests 6, results checked %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
